//--- source/storeQueuePkg.sv
package storeQueuePkg;

    // Queue and eviction buffer sizes
    localparam int NumEntries = 8;
    localparam int NumEvicted = 4;
    localparam int EntryIdxW = 3;
    localparam int EvictIdW = 2;
    localparam int SqnW = 7;

    // Store sequence number, wraps around
    typedef logic [SqnW-1:0] sqn_t;

    typedef logic [EntryIdxW-1:0] entryIdx_t;

    // Id handed to memory with each issued store
    typedef logic [EvictIdW-1:0] stId_t;

    // Byte address without bits 1:0
    typedef logic [29:0] wordAddr_t;

    typedef logic [3:0] byteMask_t;

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        SizeByte,
        SizeHalf,
        SizeWord
    } ldSize_e;

    // True when a is older than b, valid as long as both are within half the sequence range
    function automatic logic isOlder(sqn_t a, sqn_t b);
        return $signed(a - b) < 0;
    endfunction

endpackage

//--- source/sqEntryArray.sv
`timescale 1ns/1ps

module sqEntryArray (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          enqValid,
    input  storeQueuePkg::sqn_t                           enqSqN,
    input  logic                                          addrValid,
    input  storeQueuePkg::sqn_t                           addrSqN,
    input  storeQueuePkg::wordAddr_t                      addrWord,
    input  storeQueuePkg::byteMask_t                      addrMask,
    input  logic                                          dataValid,
    input  storeQueuePkg::sqn_t                           dataSqN,
    input  storeQueuePkg::word_t                          dataRaw,
    input  storeQueuePkg::sqn_t                           commitSqN,
    input  logic                                          deqAllowed,
    output logic [storeQueuePkg::NumEntries-1:0]          entryValid,
    output logic [storeQueuePkg::NumEntries-1:0]          entryAddrAvail,
    output logic [storeQueuePkg::NumEntries-1:0]          entryLoaded,
    output logic [storeQueuePkg::NumEntries-1:0]          entryReady,
    output storeQueuePkg::wordAddr_t                      entryAddr [storeQueuePkg::NumEntries],
    output storeQueuePkg::byteMask_t                      entryWmask [storeQueuePkg::NumEntries],
    output storeQueuePkg::word_t                          entryData [storeQueuePkg::NumEntries],
    output storeQueuePkg::sqn_t                           entrySqN [storeQueuePkg::NumEntries],
    output storeQueuePkg::entryIdx_t                      baseIdx,
    output logic                                          headIssue,
    output storeQueuePkg::wordAddr_t                      headAddr,
    output storeQueuePkg::word_t                          headData,
    output storeQueuePkg::byteMask_t                      headWmask,
    output logic                                          empty,
    output storeQueuePkg::sqn_t                           maxStoreSqN
);
    import storeQueuePkg::*;

    // Sequence number of the oldest entry
    sqn_t baseSqN;

    entryIdx_t enqIdx;
    entryIdx_t addrIdx;
    entryIdx_t dataIdx;
    word_t     alignedData;

    assign enqIdx = enqSqN[EntryIdxW-1:0];
    assign addrIdx = addrSqN[EntryIdxW-1:0];
    assign dataIdx = dataSqN[EntryIdxW-1:0];

    assign baseIdx = baseSqN[EntryIdxW-1:0];
    assign maxStoreSqN = baseSqN + sqn_t'(NumEntries - 1);

    assign headAddr = entryAddr[baseIdx];
    assign headData = entryData[baseIdx];
    assign headWmask = entryWmask[baseIdx];

    // Head leaves once committed and complete, if the eviction buffer can take it
    assign headIssue = deqAllowed && entryValid[baseIdx] && entryReady[baseIdx] &&
                       entryAddrAvail[baseIdx] && entryLoaded[baseIdx];

    // Raw data sits in the low lanes, move it to the lanes the mask selects
    always_comb begin
        case (entryWmask[dataIdx])
            4'b0001: alignedData = {24'b0, dataRaw[7:0]};
            4'b0010: alignedData = {16'b0, dataRaw[7:0], 8'b0};
            4'b0100: alignedData = {8'b0, dataRaw[7:0], 16'b0};
            4'b1000: alignedData = {dataRaw[7:0], 24'b0};
            4'b0011: alignedData = {16'b0, dataRaw[15:0]};
            4'b1100: alignedData = {dataRaw[15:0], 16'b0};
            default: alignedData = dataRaw;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            entryAddrAvail <= '0;
            entryLoaded <= '0;
            entryReady <= '0;
            baseSqN <= '0;
            empty <= 1'b1;
        end else begin
            // Everything older than the commit pointer may drain
            for (int i = 0; i < NumEntries; i++) begin
                if (isOlder(entrySqN[i], commitSqN)) begin
                    entryReady[i] <= 1'b1;
                end
            end

            if (headIssue) begin
                entryValid[baseIdx] <= 1'b0;
                baseSqN <= baseSqN + sqn_t'(1);
            end

            if (dataValid) begin
                entryLoaded[dataIdx] <= 1'b1;
            end

            if (addrValid) begin
                entryAddrAvail[addrIdx] <= 1'b1;
                // Nothing to write, so no data will come
                if (addrMask == '0) begin
                    entryLoaded[addrIdx] <= 1'b1;
                end
            end

            // Enqueue last so a fresh entry starts with clean flags
            if (enqValid) begin
                entryValid[enqIdx] <= 1'b1;
                entryAddrAvail[enqIdx] <= 1'b0;
                entryLoaded[enqIdx] <= 1'b0;
                entryReady[enqIdx] <= 1'b0;
            end

            empty <= ~|entryValid && !enqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (dataValid) begin
            entryData[dataIdx] <= alignedData;
        end
        if (addrValid) begin
            entryAddr[addrIdx] <= addrWord;
            entryWmask[addrIdx] <= addrMask;
        end
        if (enqValid) begin
            entrySqN[enqIdx] <= enqSqN;
        end
    end

endmodule

//--- source/sqEvictBuffer.sv
`timescale 1ns/1ps

module sqEvictBuffer (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          stall,
    input  logic                                          headIssue,
    input  storeQueuePkg::wordAddr_t                      headAddr,
    input  storeQueuePkg::word_t                          headData,
    input  storeQueuePkg::byteMask_t                      headWmask,
    input  logic                                          ackValid,
    input  storeQueuePkg::stId_t                          ackId,
    input  logic                                          ackFail,
    output logic                                          deqAllowed,
    output logic                                          stValid,
    output storeQueuePkg::stId_t                          stId,
    output storeQueuePkg::wordAddr_t                      stAddr,
    output storeQueuePkg::word_t                          stData,
    output storeQueuePkg::byteMask_t                      stWmask,
    output logic [storeQueuePkg::NumEvicted-1:0]          evValid,
    output storeQueuePkg::wordAddr_t                      evAddr [storeQueuePkg::NumEvicted],
    output storeQueuePkg::word_t                          evData [storeQueuePkg::NumEvicted],
    output storeQueuePkg::byteMask_t                      evWmask [storeQueuePkg::NumEvicted]
);
    import storeQueuePkg::*;

    // Slots stay compacted, slot 0 is the oldest store
    stId_t                 evId [NumEvicted];
    logic [NumEvicted-1:0] evIssued;
    logic [NumEvicted-1:0] usedIds;
    logic [EvictIdW:0]     evCount;
    logic [EvictIdW:0]     countAfterAck;

    logic  ackValidR;
    stId_t ackIdR;
    logic  ackFailR;

    logic [EvictIdW-1:0] ackSlot;
    logic                ackHit;
    logic                posAck;
    logic                negAck;
    stId_t               nextId;
    logic                hazard;
    logic                reissue;

    always_comb begin
        ackSlot = '0;
        ackHit = 1'b0;
        for (int i = 0; i < NumEvicted; i++) begin
            if (ackValidR && evValid[i] && evId[i] == ackIdR) begin
                ackSlot = EvictIdW'(i);
                ackHit = 1'b1;
            end
        end
    end

    assign posAck = ackHit && !ackFailR;
    assign negAck = ackHit && ackFailR;
    assign countAfterAck = evCount - (EvictIdW + 1)'(posAck);

    // Lowest free id, an id being released right now wins
    always_comb begin
        nextId = '0;
        for (int i = NumEvicted - 1; i >= 0; i--) begin
            if (!usedIds[i]) begin
                nextId = stId_t'(i);
            end
        end
        if (posAck) begin
            nextId = ackIdR;
        end
    end

    // A store to the head word that still has to be redone must go first
    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < NumEvicted; i++) begin
            if (evValid[i] && evAddr[i] == headAddr &&
                (!evIssued[i] || (ackValid && ackFail && ackId == evId[i]) ||
                 (ackValidR && ackFailR && ackIdR == evId[i]))) begin
                hazard = 1'b1;
            end
        end
    end

    assign deqAllowed = !stall && (countAfterAck < NumEvicted) && !hazard;
    assign reissue = !stall && !headIssue && evValid[0] && !evIssued[0] &&
                     !(posAck && ackSlot == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            ackValidR <= 1'b0;
            evValid <= '0;
            evIssued <= '0;
            usedIds <= '0;
            evCount <= '0;
            stValid <= 1'b0;
        end else begin
            ackValidR <= ackValid;
            if (!stall) begin
                stValid <= 1'b0;
            end

            if (posAck) begin
                for (int i = 0; i < NumEvicted - 1; i++) begin
                    if (i >= ackSlot) begin
                        evValid[i] <= evValid[i+1];
                        evIssued[i] <= evIssued[i+1];
                    end
                end
                evValid[NumEvicted-1] <= 1'b0;
                usedIds[ackIdR] <= 1'b0;
            end else if (negAck) begin
                evIssued[ackSlot] <= 1'b0;
            end

            if (headIssue) begin
                evValid[countAfterAck[EvictIdW-1:0]] <= 1'b1;
                evIssued[countAfterAck[EvictIdW-1:0]] <= 1'b1;
                usedIds[nextId] <= 1'b1;
                stValid <= 1'b1;
            end else if (reissue) begin
                evIssued[0] <= 1'b1;
                stValid <= 1'b1;
            end

            evCount <= countAfterAck + (EvictIdW + 1)'(headIssue);
        end
    end

    always_ff @(posedge clk) begin
        ackIdR <= ackId;
        ackFailR <= ackFail;

        if (posAck) begin
            for (int i = 0; i < NumEvicted - 1; i++) begin
                if (i >= ackSlot) begin
                    evAddr[i] <= evAddr[i+1];
                    evData[i] <= evData[i+1];
                    evWmask[i] <= evWmask[i+1];
                    evId[i] <= evId[i+1];
                end
            end
        end

        if (headIssue) begin
            evAddr[countAfterAck[EvictIdW-1:0]] <= headAddr;
            evData[countAfterAck[EvictIdW-1:0]] <= headData;
            evWmask[countAfterAck[EvictIdW-1:0]] <= headWmask;
            evId[countAfterAck[EvictIdW-1:0]] <= nextId;
            stId <= nextId;
            stAddr <= headAddr;
            stData <= headData;
            stWmask <= headWmask;
        end else if (reissue) begin
            // Same id as the first attempt
            stId <= evId[0];
            stAddr <= evAddr[0];
            stData <= evData[0];
            stWmask <= evWmask[0];
        end
    end

endmodule

//--- source/sqForwarding.sv
`timescale 1ns/1ps

module sqForwarding (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          ldValid,
    input  logic [31:0]                                   ldAddr,
    input  storeQueuePkg::ldSize_e                        ldSize,
    input  storeQueuePkg::sqn_t                           ldSqN,
    input  logic [storeQueuePkg::NumEntries-1:0]          entryValid,
    input  logic [storeQueuePkg::NumEntries-1:0]          entryAddrAvail,
    input  logic [storeQueuePkg::NumEntries-1:0]          entryLoaded,
    input  logic [storeQueuePkg::NumEntries-1:0]          entryReady,
    input  storeQueuePkg::wordAddr_t                      entryAddr [storeQueuePkg::NumEntries],
    input  storeQueuePkg::byteMask_t                      entryWmask [storeQueuePkg::NumEntries],
    input  storeQueuePkg::word_t                          entryData [storeQueuePkg::NumEntries],
    input  storeQueuePkg::sqn_t                           entrySqN [storeQueuePkg::NumEntries],
    input  storeQueuePkg::entryIdx_t                      baseIdx,
    input  logic [storeQueuePkg::NumEvicted-1:0]          evValid,
    input  storeQueuePkg::wordAddr_t                      evAddr [storeQueuePkg::NumEvicted],
    input  storeQueuePkg::word_t                          evData [storeQueuePkg::NumEvicted],
    input  storeQueuePkg::byteMask_t                      evWmask [storeQueuePkg::NumEvicted],
    output logic                                          fwdValid,
    output storeQueuePkg::word_t                          fwdData,
    output storeQueuePkg::byteMask_t                      fwdMask,
    output logic                                          fwdConflict
);
    import storeQueuePkg::*;

    byteMask_t readMask;
    byteMask_t lookupMask;
    word_t     lookupData;
    logic      lookupConflict;

    always_comb begin
        case (ldSize)
            SizeByte: readMask = 4'b0001 << ldAddr[1:0];
            SizeHalf: readMask = ldAddr[1] ? 4'b1100 : 4'b0011;
            default:  readMask = 4'b1111;
        endcase
    end

    always_comb begin
        entryIdx_t idx;
        // Bytes the load does not read count as already covered
        lookupMask = ~readMask;
        lookupData = '0;
        lookupConflict = 1'b0;

        // Evicted stores are older than anything still in the queue
        for (int i = 0; i < NumEvicted; i++) begin
            if (evValid[i] && evAddr[i] == ldAddr[31:2]) begin
                for (int j = 0; j < 4; j++) begin
                    if (evWmask[i][j]) begin
                        lookupData[8*j +: 8] = evData[i][8*j +: 8];
                    end
                end
                lookupMask = lookupMask | evWmask[i];
            end
        end

        // Oldest to youngest, so later stores overwrite earlier bytes
        for (int i = 0; i < NumEntries; i++) begin
            idx = baseIdx + entryIdx_t'(i);
            if (entryValid[idx] && entryAddrAvail[idx] && entryAddr[idx] == ldAddr[31:2] &&
                (isOlder(entrySqN[idx], ldSqN) || entryReady[idx])) begin
                if (entryLoaded[idx]) begin
                    for (int j = 0; j < 4; j++) begin
                        if (entryWmask[idx][j]) begin
                            lookupData[8*j +: 8] = entryData[idx][8*j +: 8];
                        end
                    end
                    lookupMask = lookupMask | entryWmask[idx];
                end else if ((entryWmask[idx] & readMask) != '0) begin
                    lookupConflict = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwdValid <= 1'b0;
        end else begin
            fwdValid <= ldValid;
        end
    end

    always_ff @(posedge clk) begin
        if (ldValid) begin
            fwdData <= lookupData;
            fwdMask <= lookupMask;
            fwdConflict <= lookupConflict;
        end
    end

endmodule

//--- source/storeQueue.sv
`timescale 1ns/1ps

module storeQueue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                enqValid,
    input  storeQueuePkg::sqn_t                 enqSqN,
    input  logic                                addrValid,
    input  storeQueuePkg::sqn_t                 addrSqN,
    input  storeQueuePkg::wordAddr_t            addrWord,
    input  storeQueuePkg::byteMask_t            addrMask,
    input  logic                                dataValid,
    input  storeQueuePkg::sqn_t                 dataSqN,
    input  storeQueuePkg::word_t                dataRaw,
    input  storeQueuePkg::sqn_t                 commitSqN,
    input  logic                                ldValid,
    input  logic [31:0]                         ldAddr,
    input  storeQueuePkg::ldSize_e              ldSize,
    input  storeQueuePkg::sqn_t                 ldSqN,
    input  logic                                stall,
    input  logic                                ackValid,
    input  storeQueuePkg::stId_t                ackId,
    input  logic                                ackFail,
    output logic                                stValid,
    output storeQueuePkg::stId_t                stId,
    output storeQueuePkg::wordAddr_t            stAddr,
    output storeQueuePkg::word_t                stData,
    output storeQueuePkg::byteMask_t            stWmask,
    output logic                                fwdValid,
    output storeQueuePkg::word_t                fwdData,
    output storeQueuePkg::byteMask_t            fwdMask,
    output logic                                fwdConflict,
    output logic                                empty,
    output storeQueuePkg::sqn_t                 maxStoreSqN
);
    import storeQueuePkg::*;

    // Entry state seen by the forwarding unit
    logic [NumEntries-1:0] entryValid;
    logic [NumEntries-1:0] entryAddrAvail;
    logic [NumEntries-1:0] entryLoaded;
    logic [NumEntries-1:0] entryReady;
    wordAddr_t             entryAddr [NumEntries];
    byteMask_t             entryWmask [NumEntries];
    word_t                 entryData [NumEntries];
    sqn_t                  entrySqN [NumEntries];
    entryIdx_t             baseIdx;

    // Head of the queue towards the eviction buffer
    logic      headIssue;
    wordAddr_t headAddr;
    word_t     headData;
    byteMask_t headWmask;
    logic      deqAllowed;

    // Stores in flight
    logic [NumEvicted-1:0] evValid;
    wordAddr_t             evAddr [NumEvicted];
    word_t                 evData [NumEvicted];
    byteMask_t             evWmask [NumEvicted];

    sqEntryArray entryArray (.*);

    sqEvictBuffer evictBuffer (.*);

    sqForwarding forwarding (.*);

endmodule

//--- verification/storeQueueTbChecks.svh
// One table row per clock cycle, inputs first, then the outputs seen in that cycle
typedef struct {
    logic      enq;
    sqn_t      enqSqN;
    logic      addrV;
    sqn_t      addrSqN;
    wordAddr_t addrWord;
    byteMask_t addrMask;
    logic      dataV;
    sqn_t      dataSqN;
    word_t     dataRaw;
    sqn_t      commit;
    logic      ld;
    wordAddr_t ldWord;
    logic [1:0] ldSize;
    sqn_t      ldSqN;
    logic      stall;
    logic      ack;
    stId_t     ackId;
    logic      ackFail;
    logic      chkSt;
    logic      expStValid;
    stId_t     expStId;
    wordAddr_t expStAddr;
    word_t     expStData;
    byteMask_t expStMask;
    logic      chkFwd;
    word_t     expFwdData;
    byteMask_t expFwdMask;
    logic      expConflict;
    logic      chkLvl;
    logic      expEmpty;
    sqn_t      expMax;
} step_t;

localparam int NumSteps = 30;
localparam wordAddr_t WordA = 30'h40;
localparam wordAddr_t WordB = 30'h80;

step_t steps [NumSteps];

function automatic word_t expandMask(byteMask_t mask);
    word_t bits;
    for (int j = 0; j < 4; j++) begin
        bits[8*j +: 8] = {8{mask[j]}};
    end
    return bits;
endfunction

task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] actVal);
    $display("FAILED at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
    $display("FAIL: see errors above");
    $fatal(1);
endtask

task automatic checkStore(logic expValid, stId_t expId, wordAddr_t expAddr, word_t expData,
                          byteMask_t expMask);
    if (stValid !== expValid) reportMismatch("stValid", expValid, stValid);
    if (expValid) begin
        if (stId !== expId) reportMismatch("stId", expId, stId);
        if (stAddr !== expAddr) reportMismatch("stAddr", expAddr, stAddr);
        if (stData !== expData) reportMismatch("stData", expData, stData);
        if (stWmask !== expMask) reportMismatch("stWmask", expMask, stWmask);
    end
endtask

// Data is compared only in the lanes the expected mask covers
task automatic checkFwd(logic expValid, word_t expData, byteMask_t expMask, logic expConflict);
    word_t lanes;
    lanes = expandMask(expMask);
    if (fwdValid !== expValid) reportMismatch("fwdValid", expValid, fwdValid);
    if (expValid) begin
        if (fwdMask !== expMask) reportMismatch("fwdMask", expMask, fwdMask);
        if ((fwdData & lanes) !== (expData & lanes)) reportMismatch("fwdData", expData, fwdData);
        if (fwdConflict !== expConflict) reportMismatch("fwdConflict", expConflict, fwdConflict);
    end
endtask

task automatic checkLevel(logic expEmpty, sqn_t expMax);
    if (empty !== expEmpty) reportMismatch("empty", expEmpty, empty);
    if (maxStoreSqN !== expMax) reportMismatch("maxStoreSqN", expMax, maxStoreSqN);
endtask

//--- verification/storeQueueTb.sv
`timescale 1ns/1ps

module storeQueueTb;
    import storeQueuePkg::*;

    logic clk;
    logic rst;
    logic enqValid;
    sqn_t enqSqN;
    logic addrValid;
    sqn_t addrSqN;
    wordAddr_t addrWord;
    byteMask_t addrMask;
    logic dataValid;
    sqn_t dataSqN;
    word_t dataRaw;
    sqn_t commitSqN;
    logic ldValid;
    logic [31:0] ldAddr;
    ldSize_e ldSize;
    sqn_t ldSqN;
    logic stall;
    logic ackValid;
    stId_t ackId;
    logic ackFail;
    logic stValid;
    stId_t stId;
    wordAddr_t stAddr;
    word_t stData;
    byteMask_t stWmask;
    logic fwdValid;
    word_t fwdData;
    byteMask_t fwdMask;
    logic fwdConflict;
    logic empty;
    sqn_t maxStoreSqN;

    int cycleCount;
    word_t d [4];

    `include "storeQueueTbChecks.svh"

    localparam int CycleLimit = NumSteps * 4 + 64;

    storeQueue DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the test did not finish within %0d cycles", CycleLimit);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    task automatic setStore(int s, stId_t id, wordAddr_t a, word_t dt, byteMask_t m);
        steps[s].chkSt = 1'b1;
        steps[s].expStValid = 1'b1;
        steps[s].expStId = id;
        steps[s].expStAddr = a;
        steps[s].expStData = dt;
        steps[s].expStMask = m;
    endtask

    task automatic buildTable();
        for (int i = 0; i < NumSteps; i++) begin
            steps[i] = '{default: '0};
            steps[i].ldSize = 2'(SizeWord);
            steps[i].commit = (i >= 19) ? sqn_t'(4) : (i >= 14) ? sqn_t'(3) : sqn_t'(0);
        end
        // Reset state
        steps[0].chkSt = 1'b1;
        steps[0].chkLvl = 1'b1;
        steps[0].expEmpty = 1'b1;
        steps[0].expMax = 7;
        // Four stores enqueued, then addressed
        for (int i = 0; i < 3; i++) begin
            steps[1+i].enq = 1'b1;
            steps[1+i].enqSqN = sqn_t'(i);
        end
        steps[10].enq = 1'b1;
        steps[10].enqSqN = 3;
        steps[4].addrV = 1'b1;
        steps[4].addrSqN = 0;
        steps[4].addrWord = WordA;
        steps[4].addrMask = 4'b0001;
        steps[5].addrV = 1'b1;
        steps[5].addrSqN = 1;
        steps[5].addrWord = WordA;
        steps[5].addrMask = 4'b1100;
        steps[6].addrV = 1'b1;
        steps[6].addrSqN = 2;
        steps[6].addrWord = WordB;
        steps[6].addrMask = 4'b1111;
        steps[11].addrV = 1'b1;
        steps[11].addrSqN = 3;
        steps[11].addrWord = WordA;
        steps[11].addrMask = 4'b0010;
        for (int i = 0; i < 3; i++) begin
            steps[7+i].dataV = 1'b1;
            steps[7+i].dataSqN = sqn_t'(i);
            steps[7+i].dataRaw = d[i];
        end
        steps[14].dataV = 1'b1;
        steps[14].dataSqN = 3;
        steps[14].dataRaw = d[3];
        // Merged word load, then the same load with an unloaded store in the way
        steps[10].ld = 1'b1;
        steps[10].ldWord = WordA;
        steps[10].ldSqN = 3;
        steps[11].chkFwd = 1'b1;
        steps[11].expFwdData = {d[1][15:0], 8'h00, d[0][7:0]};
        steps[11].expFwdMask = 4'b1101;
        steps[12].ld = 1'b1;
        steps[12].ldWord = WordA;
        steps[12].ldSqN = 4;
        steps[13].chkFwd = 1'b1;
        steps[13].expFwdData = {d[1][15:0], 8'h00, d[0][7:0]};
        steps[13].expFwdMask = 4'b1101;
        steps[13].expConflict = 1'b1;
        // In-order drain after commit
        setStore(16, 0, WordA, {24'h0, d[0][7:0]}, 4'b0001);
        setStore(17, 1, WordA, {d[1][15:0], 16'h0}, 4'b1100);
        setStore(18, 2, WordB, d[2], 4'b1111);
        steps[18].chkLvl = 1'b1;
        steps[18].expMax = 10;
        for (int i = 19; i <= 22; i++) begin
            steps[i].chkSt = 1'b1;
        end
        // Id 0 acked, id 1 failed while sqn 3 to the same word waits behind it
        steps[19].ack = 1'b1;
        steps[19].ackId = 0;
        steps[20].ack = 1'b1;
        steps[20].ackId = 1;
        steps[20].ackFail = 1'b1;
        setStore(23, 1, WordA, {d[1][15:0], 16'h0}, 4'b1100);
        // Sqn 3 takes the lowest free id and holds through the stall
        for (int i = 24; i <= 27; i++) begin
            setStore(i, 0, WordA, {16'h0, d[3][7:0], 8'h0}, 4'b0010);
        end
        for (int i = 24; i <= 26; i++) begin
            steps[i].stall = 1'b1;
        end
        steps[25].chkLvl = 1'b1;
        steps[25].expEmpty = 1'b1;
        steps[25].expMax = 11;
        steps[25].ack = 1'b1;
        steps[25].ackId = 1;
        steps[27].ld = 1'b1;
        steps[27].ldWord = WordA;
        steps[27].ldSqN = 4;
        steps[28].chkSt = 1'b1;
        steps[28].chkFwd = 1'b1;
        steps[28].expFwdData = {16'h0, d[3][7:0], 8'h0};
        steps[28].expFwdMask = 4'b0010;
        // Low half load, the upper half is not read
        steps[28].ld = 1'b1;
        steps[28].ldWord = WordA;
        steps[28].ldSize = 2'(SizeHalf);
        steps[28].ldSqN = 4;
        steps[29].chkFwd = 1'b1;
        steps[29].expFwdData = {16'h0, d[3][7:0], 8'h0};
        steps[29].expFwdMask = 4'b1110;
    endtask

    task automatic applyInputs(int s);
        enqValid <= steps[s].enq;
        enqSqN <= steps[s].enqSqN;
        addrValid <= steps[s].addrV;
        addrSqN <= steps[s].addrSqN;
        addrWord <= steps[s].addrWord;
        addrMask <= steps[s].addrMask;
        dataValid <= steps[s].dataV;
        dataSqN <= steps[s].dataSqN;
        dataRaw <= steps[s].dataRaw;
        commitSqN <= steps[s].commit;
        ldValid <= steps[s].ld;
        ldAddr <= {steps[s].ldWord, 2'b00};
        ldSize <= ldSize_e'(steps[s].ldSize);
        ldSqN <= steps[s].ldSqN;
        stall <= steps[s].stall;
        ackValid <= steps[s].ack;
        ackId <= steps[s].ackId;
        ackFail <= steps[s].ackFail;
    endtask

    initial begin
        cycleCount = 0;
        rst = 1'b1;
        enqValid = 1'b0;
        enqSqN = '0;
        addrValid = 1'b0;
        addrSqN = '0;
        addrWord = '0;
        addrMask = '0;
        dataValid = 1'b0;
        dataSqN = '0;
        dataRaw = '0;
        commitSqN = '0;
        ldValid = 1'b0;
        ldAddr = '0;
        ldSize = SizeWord;
        ldSqN = '0;
        stall = 1'b0;
        ackValid = 1'b0;
        ackId = '0;
        ackFail = 1'b0;
        void'($urandom(82556));
        for (int i = 0; i < 4; i++) begin
            d[i] = $urandom;
        end
        buildTable();
        repeat (15) @(posedge clk);
        for (int s = 0; s < NumSteps; s++) begin
            @(posedge clk);
            rst <= 1'b0;
            applyInputs(s);
            // Outputs are stable by the falling edge
            @(negedge clk);
            if (steps[s].chkSt) begin
                checkStore(steps[s].expStValid, steps[s].expStId, steps[s].expStAddr,
                           steps[s].expStData, steps[s].expStMask);
            end
            checkFwd(steps[s].chkFwd, steps[s].expFwdData, steps[s].expFwdMask,
                     steps[s].expConflict);
            if (steps[s].chkLvl) begin
                checkLevel(steps[s].expEmpty, steps[s].expMax);
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verification
source/storeQueuePkg.sv
source/sqEntryArray.sv
source/sqEvictBuffer.sv
source/sqForwarding.sv
source/storeQueue.sv
verification/storeQueueTb.sv
